// File: source/dma_pkg.sv
`default_nettype none

package dma_pkg;

    ////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int NARROW_W   = 32;
    localparam int WIDE_W     = 128;
    localparam int LANES      = WIDE_W / NARROW_W;
    localparam int ADDR_W     = 16;
    localparam int WORD_BYTES = WIDE_W / 8;
    localparam int MAX_BEATS  = 16;
    localparam int BEATS_W    = $clog2(MAX_BEATS + 1);
    localparam int PROC_W     = 7;
    localparam int SLOT_W     = 7;

    ////////////////////////////////////////////////////////////
    // data and command types
    ////////////////////////////////////////////////////////////

    typedef logic [NARROW_W-1:0] narrow_t;
    typedef logic [WIDE_W-1:0]   wide_t;

    typedef struct packed {
        logic [PROC_W-1:0] proc_id;
        logic [SLOT_W-1:0] slot_id;
    } dma_tag_t;

    // beats counts wide words, 1 to MAX_BEATS
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        dma_tag_t           tag;
        logic [BEATS_W-1:0] beats;
        logic               write;
    } dma_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        wide_t             data;
        logic              write;
    } mem_req_t;

endpackage

`default_nettype wire

// File: source/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       push,
    input  wire payload_t                   push_data,
    output logic                            push_ready,
    output logic                            pop_valid,
    output payload_t                        pop_data,
    input  wire logic                       pop,
    output logic [$clog2(DEPTH+1)-1:0]      free_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign push_ready = count_q != CNT_W'(DEPTH);
    assign pop_valid  = count_q != '0;
    assign pop_data   = mem_q[rd_ptr_q];
    assign free_count = CNT_W'(DEPTH) - count_q;

    assign do_push = push && push_ready;
    assign do_pop  = pop && pop_valid;

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: source/beat_packer.sv
`default_nettype none

module beat_packer
    import dma_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    in_valid,
    input  wire narrow_t in_data,
    output logic         in_ready,
    output logic         out_valid,
    output wide_t        out_data,
    input  wire logic    out_ready
);

    localparam int LANE_W = $clog2(LANES);

    wide_t             word_q;
    logic [LANE_W-1:0] lane_q;
    logic              full_q;
    logic              take;
    logic              last_lane;

    // a waiting word blocks intake unless it leaves this cycle
    assign in_ready  = !full_q || out_ready;
    assign out_valid = full_q;
    assign out_data  = word_q;

    assign take      = in_valid && in_ready;
    assign last_lane = lane_q == LANE_W'(LANES - 1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            lane_q <= '0;
            full_q <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                full_q <= 1'b0;
            end
            if (take) begin
                lane_q <= last_lane ? '0 : lane_q + 1'b1;
                if (last_lane) begin
                    full_q <= 1'b1;
                end
            end
        end
    end

    // new beat enters at the top, so the first beat ends in lane 0
    always_ff @(posedge clk) begin
        if (take) begin
            word_q <= {in_data, word_q[WIDE_W-1:NARROW_W]};
        end
    end

endmodule

`default_nettype wire

// File: source/beat_unpacker.sv
`default_nettype none

module beat_unpacker
    import dma_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire wide_t    in_data,
    input  wire dma_tag_t tag,
    output logic          in_ready,
    output logic          fu_valid,
    output narrow_t       fu_data,
    output dma_tag_t      fu_tag,
    input  wire logic     fu_ready,
    output logic          idle
);

    localparam int LANE_W = $clog2(LANES);

    wide_t             word_q;
    dma_tag_t          tag_q;
    logic [LANE_W-1:0] lane_q;
    logic              full_q;
    logic              last_lane;
    logic              load;

    assign last_lane = lane_q == LANE_W'(LANES - 1);

    // next word may load while the last lane is leaving
    assign in_ready = !full_q || (fu_ready && last_lane);
    assign load     = in_valid && in_ready;

    assign fu_valid = full_q;
    assign fu_data  = word_q[lane_q*NARROW_W +: NARROW_W];
    assign fu_tag   = tag_q;
    assign idle     = !full_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            lane_q <= '0;
            full_q <= 1'b0;
        end else if (load) begin
            lane_q <= '0;
            full_q <= 1'b1;
        end else if (fu_valid && fu_ready) begin
            lane_q <= last_lane ? '0 : lane_q + 1'b1;
            if (last_lane) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= in_data;
            tag_q  <= tag;
        end
    end

endmodule

`default_nettype wire

// File: source/dma_channel_fsm.sv
`default_nettype none

module dma_channel_fsm
    import dma_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     cmd_valid,
    input  wire dma_cmd_t cmd,
    output logic          cmd_ready,
    output dma_tag_t      tag,
    output logic          wr_phase,
    input  wire logic     wword_valid,
    input  wire wide_t    wword,
    output logic          wword_pop,
    output logic          mem_req_valid,
    output mem_req_t      mem_req,
    input  wire logic     mem_req_ready,
    input  wire logic     mem_rdata_valid,
    input  wire logic     buf_free,
    input  wire logic     unpack_idle,
    output logic          busy,
    output logic          done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_DRAIN
    } state_t;

    state_t             state_q;
    logic [ADDR_W-1:0]  base_q;
    dma_tag_t           tag_q;
    logic [BEATS_W-1:0] beats_q;
    logic [BEATS_W-1:0] req_cnt_q;
    logic [BEATS_W-1:0] rd_cnt_q;
    logic               done_q;
    logic               cmd_take;
    logic               req_fire;
    logic               last_req;
    logic               last_rd;

    ////////////////////////////////////////////////////////////
    // status and handshakes
    ////////////////////////////////////////////////////////////

    // done cycle already counts as idle, so hold off one more cycle
    assign cmd_ready = (state_q == ST_IDLE) && !done_q;
    assign cmd_take  = cmd_valid && cmd_ready;
    assign busy      = state_q != ST_IDLE;
    assign done      = done_q;
    assign tag       = tag_q;
    assign wr_phase  = state_q == ST_WRITE;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign last_req = req_cnt_q == beats_q - 1'b1;
    assign last_rd  = rd_cnt_q == beats_q - 1'b1;

    assign wword_pop = wr_phase && wword_valid && mem_req_ready;

    ////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_req_valid = 1'b0;
        mem_req.addr  = base_q + ADDR_W'(req_cnt_q) * ADDR_W'(WORD_BYTES);
        mem_req.data  = wr_phase ? wword : '0;
        mem_req.write = wr_phase;
        case (state_q)
            ST_WRITE: mem_req_valid = wword_valid;
            // buffer is empty on entry and holds a whole packet,
            // so reads in flight never exceed its free space
            ST_READ:  mem_req_valid = req_cnt_q != beats_q;
            default:  mem_req_valid = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q   <= ST_IDLE;
            req_cnt_q <= '0;
            rd_cnt_q  <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (cmd_take) begin
                        req_cnt_q <= '0;
                        rd_cnt_q  <= '0;
                        state_q   <= cmd.write ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (req_fire) begin
                        req_cnt_q <= req_cnt_q + 1'b1;
                        if (last_req) begin
                            state_q <= ST_IDLE;
                            done_q  <= 1'b1;
                        end
                    end
                end
                ST_READ: begin
                    if (req_fire) begin
                        req_cnt_q <= req_cnt_q + 1'b1;
                    end
                    // returns arrive in order, the last one ends the read phase
                    if (mem_rdata_valid) begin
                        rd_cnt_q <= rd_cnt_q + 1'b1;
                        if (last_rd) begin
                            state_q <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (buf_free && unpack_idle) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command fields
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            base_q  <= cmd.addr;
            tag_q   <= cmd.tag;
            beats_q <= cmd.beats;
        end
    end

endmodule

`default_nettype wire

// File: source/dma_channel.sv
`default_nettype none

module dma_channel
    import dma_pkg::*;
#(
    parameter int WDATA_DEPTH = 8,
    parameter int DATA_DEPTH  = MAX_BEATS
) (
    input  wire logic     clk,
    input  wire logic     rst,
    // command port
    input  wire logic     cmd_valid,
    input  wire dma_cmd_t cmd,
    output logic          cmd_ready,
    // write data port
    input  wire logic     wdata_valid,
    input  wire narrow_t  wdata,
    output logic          wdata_ready,
    // memory port
    output logic          mem_req_valid,
    output mem_req_t      mem_req,
    input  wire logic     mem_req_ready,
    input  wire logic     mem_rdata_valid,
    input  wire wide_t    mem_rdata,
    // forward port
    output logic          fu_valid,
    output narrow_t       fu_data,
    output dma_tag_t      fu_tag,
    input  wire logic     fu_ready,
    // status
    output logic          busy,
    output logic          done
);

    localparam int FREE_W = $clog2(DATA_DEPTH + 1);

    narrow_t            wbuf_data;
    logic               wbuf_valid;
    logic               wbuf_pop;
    logic               pk_ready;
    logic               wr_phase;
    logic               wword_valid;
    wide_t              wword;
    logic               wword_pop;
    logic               dbuf_valid;
    wide_t              dbuf_data;
    logic               dbuf_pop;
    logic [FREE_W-1:0]  data_free;
    logic               buf_free;
    logic               unpack_idle;
    dma_tag_t           tag;

    ////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////

    // beats wait here until a write command opens the packer
    assign wbuf_pop = wbuf_valid && pk_ready && wr_phase;

    sync_fifo #(
        .payload_t (narrow_t),
        .DEPTH     (WDATA_DEPTH)
    ) wdata_buf_i (
        .clk        (clk),
        .rst        (rst),
        .push       (wdata_valid),
        .push_data  (wdata),
        .push_ready (wdata_ready),
        .pop_valid  (wbuf_valid),
        .pop_data   (wbuf_data),
        .pop        (wbuf_pop),
        .free_count ()
    );

    beat_packer packer_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (wbuf_valid && wr_phase),
        .in_data   (wbuf_data),
        .in_ready  (pk_ready),
        .out_valid (wword_valid),
        .out_data  (wword),
        .out_ready (wword_pop)
    );

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    // whole buffer free means every returned word has moved on
    assign buf_free = data_free == FREE_W'(DATA_DEPTH);

    dma_channel_fsm fsm_i (
        .clk             (clk),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .cmd_ready       (cmd_ready),
        .tag             (tag),
        .wr_phase        (wr_phase),
        .wword_valid     (wword_valid),
        .wword           (wword),
        .wword_pop       (wword_pop),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rdata_valid (mem_rdata_valid),
        .buf_free        (buf_free),
        .unpack_idle     (unpack_idle),
        .busy            (busy),
        .done            (done)
    );

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    sync_fifo #(
        .payload_t (wide_t),
        .DEPTH     (DATA_DEPTH)
    ) data_buf_i (
        .clk        (clk),
        .rst        (rst),
        .push       (mem_rdata_valid),
        .push_data  (mem_rdata),
        .push_ready (),
        .pop_valid  (dbuf_valid),
        .pop_data   (dbuf_data),
        .pop        (dbuf_pop),
        .free_count (data_free)
    );

    beat_unpacker unpacker_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (dbuf_valid),
        .in_data  (dbuf_data),
        .tag      (tag),
        .in_ready (dbuf_pop),
        .fu_valid (fu_valid),
        .fu_data  (fu_data),
        .fu_tag   (fu_tag),
        .fu_ready (fu_ready),
        .idle     (unpack_idle)
    );

endmodule

`default_nettype wire

// File: bench/dma_channel_assert.sv
`default_nettype none

module dma_channel_assert
    import dma_pkg::*;
(
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     cmd_valid,
    input wire logic     cmd_ready,
    input wire logic     busy,
    input wire logic     done,
    input wire logic     mem_req_valid,
    input wire mem_req_t mem_req,
    input wire logic     mem_req_ready,
    input wire logic     fu_valid,
    input wire narrow_t  fu_data,
    input wire logic     fu_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // stalled memory request keeps address, data and direction
    req_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            $error("memory request changed while stalled");
            fail_count++;
        end

    fu_hold: assert property (@(posedge clk) disable iff (!rst)
        fu_valid && !fu_ready |=> fu_valid && $stable(fu_data))
        else begin
            $error("forward beat dropped or changed before it was taken");
            fail_count++;
        end

    // an accepted command starts a transfer and closes the command port
    busy_after_accept: assert property (@(posedge clk) disable iff (!rst)
        cmd_valid && cmd_ready |=> busy && !cmd_ready)
        else begin
            $error("accepted command did not start a transfer with cmd_ready low");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_count++;
        end

endmodule

bind dma_channel dma_channel_assert assert_i (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .busy          (busy),
    .done          (done),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .fu_valid      (fu_valid),
    .fu_data       (fu_data),
    .fu_ready      (fu_ready)
);

`default_nettype wire

// File: bench/dma_channel_tb.sv
`default_nettype none

module dma_channel_tb
    import dma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 4;
    localparam int RD_DELAY    = 3;
    localparam int MEM_WORDS   = (1 << ADDR_W) / WORD_BYTES;
    localparam int N_RANDOM    = 6;
    localparam int N_CMDS      = 9 + 2 * N_RANDOM;
    localparam int WATCHDOG_NS = N_CMDS * MAX_BEATS * LANES * 20 * CLK_PERIOD;

    logic                clk = 1'b0;
    logic                rst;
    logic                cmd_valid;
    dma_cmd_t            cmd;
    logic                cmd_ready;
    logic                wdata_valid;
    narrow_t             wdata;
    logic                wdata_ready;
    logic                mem_req_valid;
    mem_req_t            mem_req;
    logic                mem_req_ready = 1'b0;
    logic                mem_rdata_valid;
    wide_t               mem_rdata;
    logic                fu_valid;
    narrow_t             fu_data;
    dma_tag_t            fu_tag;
    logic                fu_ready = 1'b0;
    logic                busy;
    logic                done;

    integer              seed = 32'h6168_e98e;
    logic                rand_mode = 1'b0;
    wide_t               mem [MEM_WORDS];
    logic [RD_DELAY-1:0] rd_valid_pipe = '0;
    wide_t               rd_data_pipe [RD_DELAY];

    // expected forward stream and the command in flight
    narrow_t             exp_beats [$];
    dma_tag_t            exp_tag;
    logic [ADDR_W-1:0]   cur_addr;
    int                  cur_beats;
    logic                cur_write;
    logic                active = 1'b0;
    int                  req_count = 0;
    int                  mismatches = 0;
    int                  other_errors = 0;

    assign mem_rdata_valid = rd_valid_pipe[RD_DELAY-1];
    assign mem_rdata       = rd_data_pipe[RD_DELAY-1];

    dma_channel #(
        .WDATA_DEPTH (8),
        .DATA_DEPTH  (MAX_BEATS)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .cmd_ready       (cmd_ready),
        .wdata_valid     (wdata_valid),
        .wdata           (wdata),
        .wdata_ready     (wdata_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .fu_valid        (fu_valid),
        .fu_data         (fu_data),
        .fu_tag          (fu_tag),
        .fu_ready        (fu_ready),
        .busy            (busy),
        .done            (done)
    );

    initial begin : clock_gen
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // memory model and ready drivers
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : memory_model
        if (!rst) begin
            rd_valid_pipe <= '0;
        end else begin
            mem_req_ready <= rand_mode ? (($random(seed) & 3) != 0) : 1'b1;
            fu_ready      <= rand_mode ? 1'($random(seed)) : 1'b1;
            rd_valid_pipe <= {rd_valid_pipe[RD_DELAY-2:0],
                              mem_req_valid && mem_req_ready && !mem_req.write};
            for (int s = RD_DELAY - 1; s > 0; s--) begin
                rd_data_pipe[s] <= rd_data_pipe[s-1];
            end
            rd_data_pipe[0] <= mem[mem_req.addr / WORD_BYTES];
            if (mem_req_valid && mem_req_ready && mem_req.write) begin
                mem[mem_req.addr / WORD_BYTES] <= mem_req.data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference and reporting
    ////////////////////////////////////////////////////////////

    // narrow beat idx of a packet at base, lane 0 of each word first
    function automatic narrow_t expected_beat(input logic [ADDR_W-1:0] base, input int idx);
        logic [ADDR_W-1:0] addr;
        wide_t             word;
        addr = base + ADDR_W'((idx / LANES) * WORD_BYTES);
        word = mem[addr / WORD_BYTES];
        return word[(idx % LANES) * NARROW_W +: NARROW_W];
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = dut_i.assert_i.fail_count;
        $display("mismatches %0d, other errors %0d, assertion failures %0d",
                 mismatches, other_errors, assert_fails);
        if (mismatches + other_errors + assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // checkers
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare_forward
        narrow_t want;
        if (rst && fu_valid && fu_ready) begin
            assert (exp_beats.size() != 0) else
                report_failure("forward beat appeared with no read beat pending");
            if (exp_beats.size() != 0) begin
                want = exp_beats.pop_front();
                assert (fu_data == want) else
                    report_mismatch($sformatf("fu_data %h, expected %h", fu_data, want));
                assert (fu_tag == exp_tag) else
                    report_mismatch($sformatf("fu_tag %h, expected %h", fu_tag, exp_tag));
            end
        end
    end

    always @(posedge clk) begin : status_monitor
        if (rst) begin
            if (active) begin
                assert (!cmd_ready) else
                    report_mismatch("cmd_ready high while a transfer is running");
            end
            assert (busy == (active && !done)) else
                report_mismatch($sformatf("busy %0b, expected %0b", busy, active && !done));
            if (mem_req_valid && mem_req_ready) begin
                assert (active && mem_req.write == cur_write) else
                    report_mismatch($sformatf("request write flag %0b, expected %0b",
                                              mem_req.write, cur_write));
                assert (mem_req.addr == cur_addr + ADDR_W'(req_count * WORD_BYTES)) else
                    report_mismatch($sformatf("request address %h, expected %h", mem_req.addr,
                                              cur_addr + ADDR_W'(req_count * WORD_BYTES)));
                req_count++;
            end
            if (done) begin
                assert (active) else
                    report_failure("done pulse without an accepted command");
                assert (req_count == cur_beats) else
                    report_mismatch($sformatf("%0d memory requests, expected %0d",
                                              req_count, cur_beats));
                active = 1'b0;
            end
            // the accepted command sets what the requests must look like
            if (cmd_valid && cmd_ready) begin
                active    = 1'b1;
                req_count = 0;
                cur_addr  = cmd.addr;
                cur_beats = cmd.beats;
                cur_write = cmd.write;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // transfer tasks
    ////////////////////////////////////////////////////////////

    task automatic send_command(input dma_cmd_t c);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_for_done();
        @(posedge clk);
        while (!done) @(posedge clk);
    endtask

    task automatic run_write(input logic [ADDR_W-1:0] base, input int n, input dma_tag_t t);
        narrow_t sent [$];
        for (int j = 0; j < n * LANES; j++) begin
            sent.push_back(narrow_t'($random(seed)));
        end
        fork
            send_command('{addr: base, tag: t, beats: BEATS_W'(n), write: 1'b1});
            begin
                for (int j = 0; j < n * LANES; j++) begin
                    wdata_valid <= 1'b1;
                    wdata       <= sent[j];
                    @(posedge clk);
                    while (!wdata_ready) @(posedge clk);
                end
                wdata_valid <= 1'b0;
            end
        join
        wait_for_done();
        // memory now holds the sent beats, lane 0 first
        for (int j = 0; j < n * LANES; j++) begin
            assert (expected_beat(base, j) == sent[j]) else
                report_mismatch($sformatf("write beat %0d at base %h stored %h, expected %h",
                                          j, base, expected_beat(base, j), sent[j]));
        end
    endtask

    task automatic run_read(input logic [ADDR_W-1:0] base, input int n, input dma_tag_t t);
        for (int j = 0; j < n * LANES; j++) begin
            exp_beats.push_back(expected_beat(base, j));
        end
        exp_tag = t;
        send_command('{addr: base, tag: t, beats: BEATS_W'(n), write: 1'b0});
        wait_for_done();
        assert (exp_beats.size() == 0) else
            report_failure($sformatf("read ended with %0d beats never forwarded",
                                     exp_beats.size()));
        exp_beats.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [ADDR_W-1:0] base;
        int                len;
        dma_tag_t          t;
        rst         = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        // fill value marks each lane with its byte address
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int l = 0; l < LANES; l++) begin
                mem[w][l*NARROW_W +: NARROW_W] = 32'h5a5a_0000 ^ (w * WORD_BYTES + l * 4);
            end
        end
        for (int s = 0; s < RD_DELAY; s++) begin
            rd_data_pipe[s] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        assert (cmd_ready && !busy && !done && !mem_req_valid && !fu_valid) else
            report_mismatch("outputs after reset are not idle");

        // directed, no stalls
        run_write(16'h0100, 1, '{proc_id: 7'd1, slot_id: 7'd2});
        run_read(16'h0100, 1, '{proc_id: 7'd5, slot_id: 7'd17});
        run_write(16'h0400, MAX_BEATS, '{proc_id: 7'd9, slot_id: 7'd3});
        run_read(16'h0400, MAX_BEATS, '{proc_id: 7'd127, slot_id: 7'd0});
        run_read(16'h2000, 5, '{proc_id: 7'd42, slot_id: 7'd99});

        // random stalls on memory and forward ports
        rand_mode <= 1'b1;
        run_read(16'h3000, 1, '{proc_id: 7'd7, slot_id: 7'd8});
        run_read(16'h3400, MAX_BEATS, '{proc_id: 7'd64, slot_id: 7'd65});
        run_write(16'h0800, MAX_BEATS, '{proc_id: 7'd11, slot_id: 7'd12});
        run_read(16'h0800, MAX_BEATS, '{proc_id: 7'd13, slot_id: 7'd14});
        for (int k = 0; k < N_RANDOM; k++) begin
            base      = ADDR_W'($random(seed)) & ~ADDR_W'(WORD_BYTES - 1);
            len       = ($random(seed) & (MAX_BEATS - 1)) + 1;
            t.proc_id = PROC_W'($random(seed));
            t.slot_id = SLOT_W'($random(seed));
            run_write(base, len, t);
            run_read(base, len, t);
        end
        repeat (4) @(posedge clk);
        finish_run();
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_failure("timeout, transfers were still running when the time limit ran out");
        finish_run();
    end

endmodule

`default_nettype wire

// File: all.f
source/dma_pkg.sv
source/sync_fifo.sv
source/beat_packer.sv
source/beat_unpacker.sv
source/dma_channel_fsm.sv
source/dma_channel.sv
bench/dma_channel_assert.sv
bench/dma_channel_tb.sv
